// ==== sound_pkg.sv ====
package sound_pkg;

   // ******************************
   // cpu register map
   // ******************************

   typedef enum logic [7:0] {
      nr11 = 8'h11, // ch1 duty.
      nr12 = 8'h12, // ch1 volume.
      nr13 = 8'h13, // ch1 freq low.
      nr14 = 8'h14, // ch1 freq high, trigger.
      nr21 = 8'h16,
      nr22 = 8'h17,
      nr23 = 8'h18,
      nr24 = 8'h19,
      nr50 = 8'h24, // output enables.
      nr51 = 8'h25, // channel routing.
      nr52 = 8'h26  // power and status.
   } reg_addr_e;

   // ******************************
   // sample and field types
   // ******************************

   typedef logic [19:0] sample_t;
   typedef logic [10:0] freq_t;
   typedef logic [3:0]  vol_t;
   typedef logic [1:0]  duty_t;

   localparam int unsigned vol_shift = 14; // 4-bit level into 20-bit sample.

   // bit n of each entry is the output at step n.
   localparam logic [3:0][7:0] duty_table = {
      8'b0111_1110,
      8'b1000_0111,
      8'b1000_0001,
      8'b0000_0001
   };

endpackage

// ==== sound_regs.sv ====
module sound_regs (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [7:0]          addr,
   input  logic [7:0]          wdata,
   input  logic                we,
   input  logic                re,
   output logic [7:0]          rdata,
   output sound_pkg::duty_t    ch1_duty,
   output sound_pkg::duty_t    ch2_duty,
   output sound_pkg::vol_t     ch1_volume,
   output sound_pkg::vol_t     ch2_volume,
   output sound_pkg::freq_t    ch1_freq,
   output sound_pkg::freq_t    ch2_freq,
   output logic                ch1_trigger,
   output logic                ch2_trigger,
   input  logic                ch1_on,
   input  logic                ch2_on,
   output logic [7:0]          route,
   output logic                so1_en,
   output logic                so2_en
);

   sound_pkg::reg_addr_e addr_e;
   logic [7:0]           nr50_data;
   logic                 power;
   logic [7:0]           read_mux;

   assign addr_e = sound_pkg::reg_addr_e'(addr);

   // ******************************
   // register writes
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ch1_duty    <= '0;
         ch2_duty    <= '0;
         ch1_volume  <= '0;
         ch2_volume  <= '0;
         ch1_freq    <= '0;
         ch2_freq    <= '0;
         ch1_trigger <= 1'b0;
         ch2_trigger <= 1'b0;
         nr50_data   <= '0;
         route       <= '0;
         power       <= 1'b0;
      end else begin
         ch1_trigger <= 1'b0; // single cycle pulse.
         ch2_trigger <= 1'b0;
         if (we) begin
            case (addr_e)
               sound_pkg::nr11: ch1_duty <= wdata[7:6];
               sound_pkg::nr12: ch1_volume <= wdata[7:4];
               sound_pkg::nr13: ch1_freq[7:0] <= wdata;
               sound_pkg::nr14: begin
                  ch1_freq[10:8] <= wdata[2:0];
                  ch1_trigger    <= wdata[7];
               end
               sound_pkg::nr21: ch2_duty <= wdata[7:6];
               sound_pkg::nr22: ch2_volume <= wdata[7:4];
               sound_pkg::nr23: ch2_freq[7:0] <= wdata;
               sound_pkg::nr24: begin
                  ch2_freq[10:8] <= wdata[2:0];
                  ch2_trigger    <= wdata[7];
               end
               sound_pkg::nr50: nr50_data <= wdata;
               sound_pkg::nr51: route <= wdata;
               sound_pkg::nr52: power <= wdata[7]; // rest is status.
               default: ;
            endcase
         end
      end
   end

   // ******************************
   // register reads
   // ******************************

   always_comb begin
      case (addr_e)
         sound_pkg::nr11: read_mux = {ch1_duty, 6'b0};
         sound_pkg::nr12: read_mux = {ch1_volume, 4'b0};
         sound_pkg::nr13: read_mux = ch1_freq[7:0];
         sound_pkg::nr14: read_mux = {5'b0, ch1_freq[10:8]}; // trigger reads 0.
         sound_pkg::nr21: read_mux = {ch2_duty, 6'b0};
         sound_pkg::nr22: read_mux = {ch2_volume, 4'b0};
         sound_pkg::nr23: read_mux = ch2_freq[7:0];
         sound_pkg::nr24: read_mux = {5'b0, ch2_freq[10:8]};
         sound_pkg::nr50: read_mux = nr50_data;
         sound_pkg::nr51: read_mux = route;
         sound_pkg::nr52: read_mux = {power, 5'b0, ch2_on, ch1_on};
         default:         read_mux = 8'hff; // unmapped.
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (re) begin
         rdata <= read_mux;
      end
   end

   assign so1_en = nr50_data[3] & power;
   assign so2_en = nr50_data[7] & power;

endmodule

// ==== square_channel.sv ====
module square_channel (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                trigger,
   input  logic                step,
   input  sound_pkg::duty_t    duty,
   input  sound_pkg::vol_t     volume,
   input  sound_pkg::freq_t    freq,
   output logic                on,
   output sound_pkg::sample_t  level
);

   localparam logic [11:0] period_base = 12'd2048;

   logic [11:0] div;       // counts frames down to the next duty step.
   logic [11:0] reload;
   logic [2:0]  ptr;
   logic [7:0]  pattern;
   logic        high;

   assign reload = period_base - {1'b0, freq};

   // ******************************
   // divider and step pointer
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         on  <= 1'b0;
         ptr <= '0;
         div <= '0;
      end else if (trigger) begin
         on  <= 1'b1;
         ptr <= '0;
         div <= reload;
      end else if (step && on) begin
         if (div == 12'd1) begin
            div <= reload;
            ptr <= ptr + 3'd1; // wraps at 8.
         end else begin
            div <= div - 12'd1;
         end
      end
   end

   // ******************************
   // output level
   // ******************************

   assign pattern = sound_pkg::duty_table[duty];
   assign high    = on & pattern[ptr];

   always_comb begin
      if (high) begin
         level = sound_pkg::sample_t'(volume) << sound_pkg::vol_shift;
      end else begin
         level = '0;
      end
   end

endmodule

// ==== sound_mixer.sv ====
module sound_mixer #(
   parameter int unsigned credits = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  sound_pkg::sample_t  ch1_level,
   input  sound_pkg::sample_t  ch2_level,
   input  logic [7:0]          route,
   input  logic                so1_en,
   input  logic                so2_en,
   input  logic                credit_return,
   output logic                step,
   output logic                frame_valid,
   output sound_pkg::sample_t  so1,
   output sound_pkg::sample_t  so2
);

   localparam int unsigned cnt_w = $clog2(credits + 1);

   logic [cnt_w-1:0]   count;
   logic               live;   // low for the first cycle out of reset.
   logic               send;
   sound_pkg::sample_t so1_sum;
   sound_pkg::sample_t so2_sum;

   assign send = live && (count != '0);
   assign step = send; // channels advance as the frame is captured.

   // ******************************
   // credit counter
   // ******************************

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         live        <= 1'b0;
         count       <= cnt_w'(credits);
         frame_valid <= 1'b0;
      end else begin
         live        <= 1'b1;
         frame_valid <= send;
         case ({send, credit_return})
            2'b10:   count <= count - 1'b1;
            2'b01:   count <= count + 1'b1;
            default: ; // send and return cancel.
         endcase
      end
   end

   // ******************************
   // routing and sums
   // ******************************

   assign so1_sum = (route[0] ? ch1_level : '0) + (route[1] ? ch2_level : '0);
   assign so2_sum = (route[4] ? ch1_level : '0) + (route[5] ? ch2_level : '0);

   always_ff @(posedge clk) begin
      if (send) begin
         so1 <= so1_en ? so1_sum : '0;
         so2 <= so2_en ? so2_sum : '0;
      end
   end

endmodule

// ==== sound_controller.sv ====
module sound_controller #(
   parameter int unsigned credits = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [7:0]          addr,
   input  logic [7:0]          wdata,
   input  logic                we,
   input  logic                re,
   input  logic                credit_return,
   output logic [7:0]          rdata,
   output sound_pkg::sample_t  so1,
   output sound_pkg::sample_t  so2,
   output logic                frame_valid
);

   sound_pkg::duty_t   ch1_duty, ch2_duty;
   sound_pkg::vol_t    ch1_volume, ch2_volume;
   sound_pkg::freq_t   ch1_freq, ch2_freq;
   sound_pkg::sample_t ch1_level, ch2_level;
   logic               ch1_trigger, ch2_trigger;
   logic               ch1_on, ch2_on;
   logic [7:0]         route;
   logic               so1_en, so2_en;
   logic               step;

   sound_regs regs (
      .clk(clk), .rst_n(rst_n),
      .addr(addr), .wdata(wdata), .we(we), .re(re), .rdata(rdata),
      .ch1_duty(ch1_duty), .ch2_duty(ch2_duty),
      .ch1_volume(ch1_volume), .ch2_volume(ch2_volume),
      .ch1_freq(ch1_freq), .ch2_freq(ch2_freq),
      .ch1_trigger(ch1_trigger), .ch2_trigger(ch2_trigger),
      .ch1_on(ch1_on), .ch2_on(ch2_on),
      .route(route), .so1_en(so1_en), .so2_en(so2_en)
   );

   square_channel ch1 (
      .clk(clk), .rst_n(rst_n), .trigger(ch1_trigger), .step(step),
      .duty(ch1_duty), .volume(ch1_volume), .freq(ch1_freq),
      .on(ch1_on), .level(ch1_level)
   );

   square_channel ch2 (
      .clk(clk), .rst_n(rst_n), .trigger(ch2_trigger), .step(step),
      .duty(ch2_duty), .volume(ch2_volume), .freq(ch2_freq),
      .on(ch2_on), .level(ch2_level)
   );

   sound_mixer #(.credits(credits)) mixer (
      .clk(clk), .rst_n(rst_n),
      .ch1_level(ch1_level), .ch2_level(ch2_level),
      .route(route), .so1_en(so1_en), .so2_en(so2_en),
      .credit_return(credit_return), .step(step),
      .frame_valid(frame_valid), .so1(so1), .so2(so2)
   );

endmodule

// ==== sound_controller_assertions.sv ====
module sound_controller_assertions #(
   parameter int unsigned credits = 4
) (
   input logic                               clk,
   input logic                               rst_n,
   input logic [$clog2(credits + 1)-1:0]     count,
   input logic                               step,
   input logic                               frame_valid
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned cnt_w = $clog2(credits + 1);
   localparam logic [cnt_w-1:0] max_count = cnt_w'(credits);

   frame_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
      frame_valid |-> $past(count) != '0)
      else $error("frame_valid high after a cycle with no credit");

   count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      count <= max_count)
      else $error("credit count above the sink depth");

   step_causes_frame: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> frame_valid == $past(step))
      else $error("frame_valid does not follow step");

endmodule

bind sound_mixer sound_controller_assertions #(.credits(credits)) mixer_checks (
   .clk(clk), .rst_n(rst_n), .count(count), .step(step), .frame_valid(frame_valid)
);

// ==== tb_sound_controller.sv ====
module tb_sound_controller;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned credits     = 4;
   localparam int unsigned num_frames  = 600;
   localparam int unsigned cycle_limit = num_frames * (credits + 8) + 2000;

   localparam logic [7:0] reg_list [11] = '{
      sound_pkg::nr11, sound_pkg::nr12, sound_pkg::nr13, sound_pkg::nr14,
      sound_pkg::nr21, sound_pkg::nr22, sound_pkg::nr23, sound_pkg::nr24,
      sound_pkg::nr50, sound_pkg::nr51, sound_pkg::nr52
   };
   localparam logic [7:0] unmapped_list [4] = '{8'h00, 8'h15, 8'h27, 8'hff};

   logic               clk, rst_n, we, re, credit_return, frame_valid;
   logic [7:0]         addr, wdata, rdata;
   sound_pkg::sample_t so1, so2;

   // ******************************
   // reference model state
   // ******************************

   sound_pkg::duty_t   m_duty1, m_duty2;
   sound_pkg::vol_t    m_vol1, m_vol2;
   sound_pkg::freq_t   m_freq1, m_freq2;
   logic               m_trig1, m_trig2, m_on1, m_on2, m_power, m_live, m_fv;
   logic [2:0]         m_ptr1, m_ptr2;
   logic [11:0]        m_div1, m_div2;
   logic [7:0]         m_nr50, m_route, m_rdata;
   sound_pkg::sample_t m_so1, m_so2;
   int unsigned        m_count;

   logic [31:0]        rng;
   logic               returns_on;
   int unsigned        cycle, frames_seen, returned, ready;
   int unsigned        hold_q[$]; // release cycle of each held frame.

   sound_controller #(.credits(credits)) dut (
      .clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata), .we(we), .re(re),
      .credit_return(credit_return), .rdata(rdata), .so1(so1), .so2(so2),
      .frame_valid(frame_valid)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic sound_pkg::sample_t chan_level(input logic on, input logic [2:0] ptr,
                                                     input sound_pkg::duty_t duty,
                                                     input sound_pkg::vol_t vol);
      logic [7:0] pattern;
      pattern = sound_pkg::duty_table[duty];
      if (on && pattern[ptr]) begin
         return sound_pkg::sample_t'(vol) << sound_pkg::vol_shift;
      end else begin
         return '0;
      end
   endfunction

   function automatic logic [7:0] model_read(input logic [7:0] a);
      case (a)
         sound_pkg::nr11: return {m_duty1, 6'b0};
         sound_pkg::nr12: return {m_vol1, 4'b0};
         sound_pkg::nr13: return m_freq1[7:0];
         sound_pkg::nr14: return {5'b0, m_freq1[10:8]};
         sound_pkg::nr21: return {m_duty2, 6'b0};
         sound_pkg::nr22: return {m_vol2, 4'b0};
         sound_pkg::nr23: return m_freq2[7:0];
         sound_pkg::nr24: return {5'b0, m_freq2[10:8]};
         sound_pkg::nr50: return m_nr50;
         sound_pkg::nr51: return m_route;
         sound_pkg::nr52: return {m_power, 5'b0, m_on2, m_on1};
         default:         return 8'hff;
      endcase
   endfunction

   task automatic advance_channel(inout logic on, inout logic [2:0] ptr, inout logic [11:0] div,
                                  input logic trig, input logic send,
                                  input sound_pkg::freq_t freq);
      if (trig) begin
         on  = 1'b1;
         ptr = 3'd0;
         div = 12'd2048 - {1'b0, freq};
      end else if (send && on) begin
         if (div == 12'd1) begin
            div = 12'd2048 - {1'b0, freq};
            ptr = ptr + 3'd1;
         end else begin
            div = div - 12'd1;
         end
      end
   endtask

   task automatic model_clock();
      logic               send;
      sound_pkg::sample_t lv1, lv2, sum1, sum2;
      if (!rst_n) begin
         {m_duty1, m_duty2, m_vol1, m_vol2} = '0;
         {m_freq1, m_freq2, m_trig1, m_trig2, m_on1, m_on2} = '0;
         {m_ptr1, m_ptr2, m_div1, m_div2} = '0;
         {m_nr50, m_route, m_rdata, m_power, m_live, m_fv} = '0;
         m_count = credits;
      end else begin
         send = m_live && (m_count != 0);
         lv1  = chan_level(m_on1, m_ptr1, m_duty1, m_vol1);
         lv2  = chan_level(m_on2, m_ptr2, m_duty2, m_vol2);
         sum1 = (m_route[0] ? lv1 : 20'd0) + (m_route[1] ? lv2 : 20'd0);
         sum2 = (m_route[4] ? lv1 : 20'd0) + (m_route[5] ? lv2 : 20'd0);
         if (send) begin
            m_so1 = (m_nr50[3] && m_power) ? sum1 : 20'd0;
            m_so2 = (m_nr50[7] && m_power) ? sum2 : 20'd0;
         end
         if (re) m_rdata = model_read(addr); // sees the on flags before this edge.
         m_fv = send;
         if (send && !credit_return) m_count = m_count - 1;
         else if (!send && credit_return) m_count = m_count + 1;
         advance_channel(m_on1, m_ptr1, m_div1, m_trig1, send, m_freq1);
         advance_channel(m_on2, m_ptr2, m_div2, m_trig2, send, m_freq2);
         m_trig1 = we && (addr == sound_pkg::nr14) && wdata[7];
         m_trig2 = we && (addr == sound_pkg::nr24) && wdata[7];
         if (we) begin
            case (addr)
               sound_pkg::nr11: m_duty1 = wdata[7:6];
               sound_pkg::nr12: m_vol1 = wdata[7:4];
               sound_pkg::nr13: m_freq1[7:0] = wdata;
               sound_pkg::nr14: m_freq1[10:8] = wdata[2:0];
               sound_pkg::nr21: m_duty2 = wdata[7:6];
               sound_pkg::nr22: m_vol2 = wdata[7:4];
               sound_pkg::nr23: m_freq2[7:0] = wdata;
               sound_pkg::nr24: m_freq2[10:8] = wdata[2:0];
               sound_pkg::nr50: m_nr50 = wdata;
               sound_pkg::nr51: m_route = wdata;
               sound_pkg::nr52: m_power = wdata[7];
               default: ;
            endcase
         end
         m_live = 1'b1;
      end
   endtask

   // ******************************
   // checks and sink
   // ******************************

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_rdata(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_sample(input string name, input sound_pkg::sample_t got,
                               input sound_pkg::sample_t exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_valid(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic release_credit();
      for (int k = hold_q.size() - 1; k >= 0; k--) begin
         if (hold_q[k] <= cycle) begin
            ready++;
            hold_q.delete(k);
         end
      end
      credit_return = 1'b0;
      if (returns_on && ready > 0) begin
         credit_return = 1'b1; // one credit per cycle.
         ready--;
         returned++;
      end
   endtask

   task automatic cycle_step();
      @(posedge clk);
      model_clock();
      @(negedge clk);
      cycle++;
      if (cycle >= cycle_limit) begin
         stop_with_failure("cycle limit reached before all frames arrived");
      end
      check_rdata("rdata", rdata, m_rdata);
      check_valid("frame_valid", frame_valid, m_fv);
      if (frame_valid) begin
         check_sample("so1", so1, m_so1);
         check_sample("so2", so2, m_so2);
         frames_seen++;
         rng = xorshift32(rng);
         hold_q.push_back(cycle + {29'b0, rng[2:0]}); // held 0 to 7 cycles.
      end
      if (frames_seen > returned + credits) begin
         stop_with_failure("more frames sent than credits allow");
      end
      release_credit();
   endtask

   task automatic random_bus_op();
      logic [3:0] idx;
      rng   = xorshift32(rng);
      idx   = 4'(rng[7:4] % 11);
      addr  = reg_list[idx];
      wdata = rng[15:8];
      we    = 1'b0;
      re    = 1'b0;
      case (rng[2:0])
         3'd0, 3'd1, 3'd2: begin
            we = 1'b1;
            if ((addr == sound_pkg::nr13 || addr == sound_pkg::nr23) && rng[16]) begin
               wdata = {4'hf, rng[11:8]}; // short periods keep the pointer moving.
            end
            if ((addr == sound_pkg::nr14 || addr == sound_pkg::nr24) && rng[17]) begin
               wdata = {rng[15], 4'b0, 3'b111};
            end
            if (rng[19] && rng[20]) addr = rng[31:24];
         end
         3'd3, 3'd4: begin
            re = 1'b1;
            if (rng[18]) addr = rng[31:24];
         end
         default: ;
      endcase
   endtask

   initial begin
      rst_n         = 1'b0;
      addr          = '0;
      wdata         = '0;
      we            = 1'b0;
      re            = 1'b0;
      credit_return = 1'b0;
      rng           = 32'd80;
      cycle         = 0;
      frames_seen   = 0;
      returned      = 0;
      ready         = 0;
      returns_on    = 1'b0;
      repeat (16) cycle_step();
      rst_n = 1'b1;
      foreach (reg_list[i]) begin
         addr = reg_list[i];
         re   = 1'b1;
         cycle_step();
      end
      foreach (unmapped_list[i]) begin
         addr = unmapped_list[i];
         cycle_step();
      end
      re = 1'b0;
      repeat (8) cycle_step();
      if (frames_seen != credits) begin
         stop_with_failure("wrong number of frames before the first credit return");
      end
      returns_on = 1'b1;
      while (frames_seen < num_frames) begin
         random_bus_op();
         cycle_step();
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// ==== flist.f ====
sound_pkg.sv
sound_regs.sv
square_channel.sv
sound_mixer.sv
sound_controller.sv
sound_controller_assertions.sv
tb_sound_controller.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the sound controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module tb_sound_controller -f flist.f -o sim_tb; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi

echo "simulation completed"
exit 0
